//--- tb/vmul_stim.txt
// ctrl(op eew s1 s2 masked, one hex digit each) op1 op2 op3 mask exp_res exp_mask
// op 0 vmul 1 vmulh 2 vmacc, eew 0 byte 1 half 2 word
// vmul, bytes
00000 02030405 03040506 00000000 0 060c141e f
00110 ff80107f ff021011 00000000 0 0100006f f
00001 0a0b0c0d 02020202 00000000 5 1416181a 5
00000 02030405 03040506 ffffffff 0 060c141e f
// vmul, halfwords
01000 00030100 00050100 00000000 0 000f0000 f
01110 ffff8000 00020002 00000000 0 fffe0000 f
01001 12340010 00100010 00000000 a 23400100 a
// vmul, words
02000 00010000 00010000 00000000 0 00000000 f
02000 12345678 00000010 00000000 0 23456780 f
02110 ffffffff ffffffff 00000000 0 00000001 f
02001 0000ffff 0000ffff 00000000 3 fffe0001 3
// vmulh, bytes, uu ss su us
10000 ff807f02 ff02ff80 00000000 0 fe017e01 f
10110 ff807f02 ff02ff80 00000000 0 00ffffff f
10100 ff807f02 ff02ff80 00000000 0 ffff7e01 f
10010 ff807f02 ff02ff80 ffffffff 0 ff01ffff f
// vmulh, halfwords, uu ss su us
11000 8000ffff ffff0003 00000000 0 7fff0002 f
11110 8000ffff ffff0003 00000000 0 0000ffff f
11100 8000ffff ffff0003 00000000 0 8000ffff f
11011 8000ffff ffff0003 00000000 6 ffff0002 6
// vmulh, words, uu ss su us
12000 ffffffff ffffffff 00000000 0 fffffffe f
12110 ffffffff ffffffff 00000000 0 00000000 f
12100 ffffffff ffffffff 00000000 0 ffffffff f
12010 ffffffff ffffffff 00000000 0 ffffffff f
12000 80000000 80000000 00000000 0 40000000 f
12110 80000000 80000000 00000000 0 40000000 f
12100 80000000 80000000 12345678 0 c0000000 f
12000 12345678 00010000 00000000 0 00001234 f
// vmacc
20000 02030405 03040506 01010101 0 070d151f f
20110 ff80107f ff021011 ff0101ff 0 0001016e f
21000 00030100 00050100 fff10001 0 00000001 f
22000 12345678 00000010 00000001 0 23456781 f
22001 0000ffff 0000ffff 0001ffff 9 00000000 9

//--- all.f
design/vmul_pkg.sv
design/vmul_pipe_ctrl.sv
design/vmul_operand_prep.sv
design/vmul_block.sv
design/vmul_result_compose.sv
design/vmul_top.sv
tb/vmul_clk_gen.sv
tb/vmul_assert.sv
tb/vmul_tb.sv

//--- tb/vmul_tb.sv
//////////////////////////////
// testbench top for the SIMD multiplier
// reads vectors from the stim file and checks results in order
//////////////////////////////

`default_nettype none

module vmul_tb import vmul_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned MUL_OP_W = 32;
    localparam int unsigned LANES    = MUL_OP_W / BYTE_W;
    localparam int          MAX_VEC  = 64;
    localparam int          WPV      = 7;

    logic                clk_i;
    logic                async_rst_ni;
    logic                in_valid_i;
    logic                in_ready_o;
    vmul_op_e            in_op_i;
    vmul_eew_e           in_eew_i;
    logic                in_op1_signed_i;
    logic                in_op2_signed_i;
    logic                in_masked_i;
    logic [MUL_OP_W-1:0] in_op1_i;
    logic [MUL_OP_W-1:0] in_op2_i;
    logic [MUL_OP_W-1:0] in_op3_i;
    logic [LANES-1:0]    in_mask_i;
    logic                out_valid_o;
    logic                out_ready_i;
    logic [MUL_OP_W-1:0] out_res_o;
    logic [LANES-1:0]    out_mask_o;

    logic [31:0] stim_mem [MAX_VEC*WPV];
    int          num_vec;
    int          cycles;
    int          limit;
    int          rx_count;
    int          tests_ok;
    int          tests_bad;
    int          other_errors;
    int          exp_q [$];
    int          acc_q [$];

    vmul_clk_gen u_clk_gen (
        .clk_o  (clk_i),
        .rst_no (async_rst_ni)
    );

    vmul_top #(
        .MUL_OP_W (MUL_OP_W)
    ) DUT (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .in_op_i         (in_op_i),
        .in_eew_i        (in_eew_i),
        .in_op1_signed_i (in_op1_signed_i),
        .in_op2_signed_i (in_op2_signed_i),
        .in_masked_i     (in_masked_i),
        .in_op1_i        (in_op1_i),
        .in_op2_i        (in_op2_i),
        .in_op3_i        (in_op3_i),
        .in_mask_i       (in_mask_i),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_res_o       (out_res_o),
        .out_mask_o      (out_mask_o)
    );

    bind vmul_top vmul_assert #(
        .MUL_OP_W (MUL_OP_W)
    ) u_assert (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_res_o    (out_res_o),
        .out_mask_o   (out_mask_o)
    );

    // drive one vector and hold it until the DUT takes it
    task automatic send_vector(input int idx);
        logic [31:0] ctrl;
        ctrl = stim_mem[idx*WPV];
        in_valid_i      <= 1'b1;
        in_op_i         <= vmul_op_e'(ctrl[17:16]);
        in_eew_i        <= vmul_eew_e'(ctrl[13:12]);
        in_op1_signed_i <= ctrl[8];
        in_op2_signed_i <= ctrl[4];
        in_masked_i     <= ctrl[0];
        in_op1_i        <= stim_mem[idx*WPV+1];
        in_op2_i        <= stim_mem[idx*WPV+2];
        in_op3_i        <= stim_mem[idx*WPV+3];
        in_mask_i       <= stim_mem[idx*WPV+4][LANES-1:0];
        @(negedge clk_i);
        while (!in_ready_o) begin
            @(negedge clk_i);
        end
        exp_q.push_back(idx);
        acc_q.push_back(cycles + 1);
        @(posedge clk_i);
    endtask

    initial begin
        in_valid_i      = 1'b0;
        in_op_i         = MUL_VMUL;
        in_eew_i        = VSEW_8;
        in_op1_signed_i = 1'b0;
        in_op2_signed_i = 1'b0;
        in_masked_i     = 1'b0;
        in_op1_i        = '0;
        in_op2_i        = '0;
        in_op3_i        = '0;
        in_mask_i       = '0;
        out_ready_i     = 1'b0;
        cycles          = 0;
        rx_count        = 0;
        tests_ok        = 0;
        tests_bad       = 0;
        other_errors    = 0;
        // unread words keep an address-tagged fill
        for (int i = 0; i < MAX_VEC*WPV; i++) begin
            stim_mem[i] = 32'hf0000000 | 32'(i);
        end
        $readmemh("tb/vmul_stim.txt", stim_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC &&
               stim_mem[num_vec*WPV] != (32'hf0000000 | 32'(num_vec*WPV))) begin
            num_vec++;
        end
        limit = 20 * num_vec + 100;
        if (num_vec == 0) begin
            $display("no vectors could be read from the stim file");
            other_errors++;
        end

        @(posedge async_rst_ni);
        @(negedge clk_i);
        if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
            $display("error at %0t: after reset out_valid_o=%b in_ready_o=%b",
                     $time, out_valid_o, in_ready_o);
            other_errors++;
        end

        @(posedge clk_i);
        for (int i = 0; i < num_vec; i++) begin
            send_vector(i);
        end
        in_valid_i <= 1'b0;

        while (rx_count < num_vec) begin
            @(negedge clk_i);
        end
        // catch any extra output beat
        repeat (8) @(negedge clk_i);

        $display("tests: %0d run, %0d passed, %0d failed, %0d other errors, %0d assertion fails",
                 num_vec, tests_ok, tests_bad, other_errors, DUT.u_assert.fail_count);
        if (tests_bad == 0 && other_errors == 0 && DUT.u_assert.fail_count == 0 &&
            tests_ok == num_vec) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // first half drains freely so latency is fixed, then random stalls
    initial begin : ready_pattern
        void'($urandom(32'hedade604));
        forever begin
            @(posedge clk_i);
            if (async_rst_ni) begin
                if (rx_count < num_vec / 2) begin
                    out_ready_i <= 1'b1;
                end else begin
                    out_ready_i <= $urandom % 2;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run exceeded %0d cycles with %0d of %0d results received",
                     limit, rx_count, num_vec);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // output checking

    always @(negedge clk_i) begin
        int  idx;
        int  acc_edge;
        bit  ok;
        if (async_rst_ni && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: output beat with no item outstanding", $time);
                other_errors++;
            end else begin
                idx      = exp_q.pop_front();
                acc_edge = acc_q.pop_front();
                ok       = 1'b1;
                if (out_res_o !== stim_mem[idx*WPV+5]) begin
                    $display("error at %0t: test %0d result %h expected %h",
                             $time, idx, out_res_o, stim_mem[idx*WPV+5]);
                    ok = 1'b0;
                end
                if (out_mask_o !== stim_mem[idx*WPV+6][LANES-1:0]) begin
                    $display("error at %0t: test %0d mask %h expected %h",
                             $time, idx, out_mask_o, stim_mem[idx*WPV+6][LANES-1:0]);
                    ok = 1'b0;
                end
                if (idx < num_vec / 2 && cycles + 1 != acc_edge + 4) begin
                    $display("error at %0t: test %0d took %0d cycles instead of 4",
                             $time, idx, cycles + 1 - acc_edge);
                    ok = 1'b0;
                end
                if (ok) begin
                    tests_ok++;
                    $display("test %0d ok", idx);
                end else begin
                    tests_bad++;
                    $display("test %0d wrong", idx);
                end
                rx_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/vmul_assert.sv
//////////////////////////////
// handshake and reset properties of the multiplier top
// bound into the DUT from the testbench top
//////////////////////////////

`default_nettype none

module vmul_assert #(
    parameter int unsigned MUL_OP_W = 32
) (
    input logic                  clk_i,
    input logic                  async_rst_ni,
    input logic                  in_ready_o,
    input logic                  out_valid_o,
    input logic                  out_ready_i,
    input logic [MUL_OP_W-1:0]   out_res_o,
    input logic [MUL_OP_W/8-1:0] out_mask_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count;

    initial begin
        fail_count = 0;
    end

    // a stalled output keeps its valid and its data
    hold_until_accepted: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_res_o) && $stable(out_mask_o)
    ) else begin
        $error("output changed while stalled");
        fail_count++;
    end

    no_valid_in_reset: assert property (
        @(posedge clk_i) !async_rst_ni |-> !out_valid_o
    ) else begin
        $error("out_valid_o high during reset");
        fail_count++;
    end

    // a free output drains the whole pipeline
    ready_when_drained: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        out_ready_i |-> in_ready_o
    ) else begin
        $error("in_ready_o low while out_ready_i high");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- tb/vmul_clk_gen.sv
//////////////////////////////
// testbench clock and reset source
// 8 ns clock, reset held low for the first two cycles
//////////////////////////////

`default_nettype none

module vmul_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b1;
        // reset falls just after time zero
        #1 rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_no <= 1'b1;
    end

    always #4 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- design/vmul_top.sv
//////////////////////////////
// SIMD integer multiplier with four pipeline stages
// valid/ready on both sides and a byte mask per item
//////////////////////////////

`default_nettype none

module vmul_top import vmul_pkg::*; #(
    parameter int unsigned MUL_OP_W = 32
) (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  vmul_op_e                     in_op_i,
    input  vmul_eew_e                    in_eew_i,
    input  logic                         in_op1_signed_i,
    input  logic                         in_op2_signed_i,
    input  logic                         in_masked_i,
    input  logic [MUL_OP_W-1:0]          in_op1_i,
    input  logic [MUL_OP_W-1:0]          in_op2_i,
    input  logic [MUL_OP_W-1:0]          in_op3_i,
    input  logic [MUL_OP_W/BYTE_W-1:0]   in_mask_i,
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output logic [MUL_OP_W-1:0]          out_res_o,
    output logic [MUL_OP_W/BYTE_W-1:0]   out_mask_o
);

    localparam int unsigned LANES = MUL_OP_W / BYTE_W;

    logic                         s1_en, s2_en, s3_en, s4_en;
    vmul_op_e                     s1_op, s3_op;
    vmul_eew_e                    s1_eew, s3_eew;
    logic                         s1_op1_signed, s1_op2_signed;
    logic [LANES*LANE_OP_W-1:0]   lane_op1, lane_op2;
    logic [LANES*LANE_ACC_W-1:0]  lane_acc;
    logic [LANES*LANE_RES_W-1:0]  lane_res;

    vmul_pipe_ctrl #(
        .MUL_OP_W        (MUL_OP_W)
    ) u_pipe_ctrl (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .in_valid_i      (in_valid_i),
        .in_masked_i     (in_masked_i),
        .out_ready_i     (out_ready_i),
        .in_op_i         (in_op_i),
        .in_eew_i        (in_eew_i),
        .in_op1_signed_i (in_op1_signed_i),
        .in_op2_signed_i (in_op2_signed_i),
        .in_mask_i       (in_mask_i),
        .in_ready_o      (in_ready_o),
        .out_valid_o     (out_valid_o),
        .s1_en_o         (s1_en),
        .s2_en_o         (s2_en),
        .s3_en_o         (s3_en),
        .s4_en_o         (s4_en),
        .s1_op_o         (s1_op),
        .s1_eew_o        (s1_eew),
        .s1_op1_signed_o (s1_op1_signed),
        .s1_op2_signed_o (s1_op2_signed),
        .s3_op_o         (s3_op),
        .s3_eew_o        (s3_eew),
        .out_mask_o      (out_mask_o)
    );

    vmul_operand_prep #(
        .MUL_OP_W        (MUL_OP_W)
    ) u_operand_prep (
        .clk_i           (clk_i),
        .s1_en_i         (s1_en),
        .s2_en_i         (s2_en),
        .op1_i           (in_op1_i),
        .op2_i           (in_op2_i),
        .op3_i           (in_op3_i),
        .s1_op_i         (s1_op),
        .s1_eew_i        (s1_eew),
        .s1_op1_signed_i (s1_op1_signed),
        .s1_op2_signed_i (s1_op2_signed),
        .lane_op1_o      (lane_op1),
        .lane_op2_o      (lane_op2),
        .lane_acc_o      (lane_acc)
    );

    // one multiplier per byte lane, all loading in stage 3
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        vmul_block u_block (
            .clk_i (clk_i),
            .en_i  (s3_en),
            .op1_i (lane_op1[LANE_OP_W*g +: LANE_OP_W]),
            .op2_i (lane_op2[LANE_OP_W*g +: LANE_OP_W]),
            .acc_i (lane_acc[LANE_ACC_W*g +: LANE_ACC_W]),
            .res_o (lane_res[LANE_RES_W*g +: LANE_RES_W])
        );
    end

    vmul_result_compose #(
        .MUL_OP_W   (MUL_OP_W)
    ) u_result_compose (
        .clk_i      (clk_i),
        .en_i       (s4_en),
        .lane_res_i (lane_res),
        .s3_op_i    (s3_op),
        .s3_eew_i   (s3_eew),
        .res_o      (out_res_o)
    );

endmodule

`default_nettype wire

//--- design/vmul_result_compose.sv
//////////////////////////////
// element result selection from lane products (stage 4)
// 32-bit elements are summed from four halfword partial products
//////////////////////////////

`default_nettype none

module vmul_result_compose import vmul_pkg::*; #(
    parameter int unsigned MUL_OP_W = 32
) (
    input  logic                                   clk_i,
    input  logic                                   en_i,
    input  logic [MUL_OP_W/BYTE_W*LANE_RES_W-1:0]  lane_res_i,
    input  vmul_op_e                               s3_op_i,
    input  vmul_eew_e                              s3_eew_i,
    output logic [MUL_OP_W-1:0]                    res_o
);

    localparam int unsigned LANES   = MUL_OP_W / BYTE_W;
    localparam int unsigned GROUP_W = 4 * BYTE_W;
    localparam int unsigned HALF_W  = 2 * BYTE_W;
    localparam int unsigned PROD_W  = 2 * GROUP_W;
    localparam int unsigned EXT_W   = PROD_W - LANE_RES_W;

    logic                take_high;
    logic [MUL_OP_W-1:0] res_d, res_q;

    assign take_high = (s3_op_i == MUL_VMULH);

    always_comb begin : compose
        logic [LANE_RES_W-1:0] r [4];
        logic [PROD_W-1:0]     p;
        res_d = '0;
        for (int g = 0; g < LANES / 4; g++) begin
            for (int k = 0; k < 4; k++) begin
                r[k] = lane_res_i[LANE_RES_W*(4*g+k) +: LANE_RES_W];
            end

            // full 64-bit product of the group, only bits 31:0 of hi*hi matter
            p = {{EXT_W{r[0][LANE_RES_W-1]}}, r[0]}
              + ({{EXT_W{r[1][LANE_RES_W-1]}}, r[1]} << HALF_W)
              + ({{EXT_W{r[2][LANE_RES_W-1]}}, r[2]} << HALF_W)
              + {r[3][GROUP_W-1:0], {GROUP_W{1'b0}}};

            unique case (s3_eew_i)
                VSEW_8: begin
                    for (int k = 0; k < 4; k++) begin
                        res_d[GROUP_W*g+BYTE_W*k +: BYTE_W] = take_high ?
                            r[k][BYTE_W +: BYTE_W] : r[k][0 +: BYTE_W];
                    end
                end
                VSEW_16: begin
                    // halfword elements sit in the even lanes
                    for (int k = 0; k < 2; k++) begin
                        res_d[GROUP_W*g+HALF_W*k +: HALF_W] = take_high ?
                            r[2*k][HALF_W +: HALF_W] : r[2*k][0 +: HALF_W];
                    end
                end
                VSEW_32: begin
                    res_d[GROUP_W*g +: GROUP_W] = take_high ?
                        p[GROUP_W +: GROUP_W] : p[0 +: GROUP_W];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin : result_reg
        if (en_i) begin
            res_q <= res_d;
        end
    end

    assign res_o = res_q;

endmodule

`default_nettype wire

//--- design/vmul_block.sv
//////////////////////////////
// one byte-lane multiplier with accumulate
// instantiated once per lane by the top level
//////////////////////////////

`default_nettype none

module vmul_block (
    input  logic        clk_i,
    input  logic        en_i,
    input  logic [16:0] op1_i,
    input  logic [16:0] op2_i,
    input  logic [15:0] acc_i,
    output logic [32:0] res_o
);

    logic signed [33:0] prod;
    logic signed [33:0] sum;
    logic        [32:0] res_q;

    // both lane operands arrive already sign or zero extended
    assign prod = $signed(op1_i) * $signed(op2_i);

    // accumulator slot is an unsigned 16-bit chunk
    assign sum = prod + $signed({18'b0, acc_i});

    // lane results always fit in 33 bits
    always_ff @(posedge clk_i) begin : product_reg
        if (en_i) begin
            res_q <= sum[32:0];
        end
    end

    assign res_o = res_q;

endmodule

`default_nettype wire

//--- design/vmul_operand_prep.sv
//////////////////////////////
// operand capture and lane operand forming (stages 1 and 2)
//////////////////////////////

`default_nettype none

module vmul_operand_prep import vmul_pkg::*; #(
    parameter int unsigned MUL_OP_W = 32
) (
    input  logic                                   clk_i,
    input  logic                                   s1_en_i,
    input  logic                                   s2_en_i,
    input  logic [MUL_OP_W-1:0]                    op1_i,
    input  logic [MUL_OP_W-1:0]                    op2_i,
    input  logic [MUL_OP_W-1:0]                    op3_i,
    input  vmul_op_e                               s1_op_i,
    input  vmul_eew_e                              s1_eew_i,
    input  logic                                   s1_op1_signed_i,
    input  logic                                   s1_op2_signed_i,
    output logic [MUL_OP_W/BYTE_W*LANE_OP_W-1:0]   lane_op1_o,
    output logic [MUL_OP_W/BYTE_W*LANE_OP_W-1:0]   lane_op2_o,
    output logic [MUL_OP_W/BYTE_W*LANE_ACC_W-1:0]  lane_acc_o
);

    localparam int unsigned LANES   = MUL_OP_W / BYTE_W;
    localparam int unsigned GROUP_W = 4 * BYTE_W;
    localparam int unsigned HALF_W  = 2 * BYTE_W;
    localparam int unsigned OPS_W   = LANES * LANE_OP_W;
    localparam int unsigned ACCS_W  = LANES * LANE_ACC_W;

    logic [MUL_OP_W-1:0] a_q, b_q, c_q;
    logic [OPS_W-1:0]    op1_d, op2_d, op1_q, op2_q;
    logic [ACCS_W-1:0]   acc_d, acc_q;

    function automatic logic [LANE_OP_W-1:0] ext_byte(input logic [BYTE_W-1:0] v,
                                                      input logic sgn);
        return {{(LANE_OP_W-BYTE_W){sgn & v[BYTE_W-1]}}, v};
    endfunction

    function automatic logic [LANE_OP_W-1:0] ext_half(input logic [HALF_W-1:0] v,
                                                      input logic sgn);
        return {{(LANE_OP_W-HALF_W){sgn & v[HALF_W-1]}}, v};
    endfunction

    always_ff @(posedge clk_i) begin : stage1_regs
        if (s1_en_i) begin
            a_q <= op1_i;
            b_q <= op2_i;
            c_q <= op3_i;
        end
    end

    //////////////////////////////
    // lane operands per 32-bit group

    always_comb begin : lane_forming
        logic [GROUP_W-1:0] a, b, c;
        int unsigned        l;
        op1_d = '0;
        op2_d = '0;
        acc_d = '0;
        for (int g = 0; g < LANES / 4; g++) begin
            a = a_q[GROUP_W*g +: GROUP_W];
            b = b_q[GROUP_W*g +: GROUP_W];
            c = c_q[GROUP_W*g +: GROUP_W];
            l = 4 * g;
            unique case (s1_eew_i)
                VSEW_8: begin
                    for (int k = 0; k < 4; k++) begin
                        op1_d[LANE_OP_W*(l+k) +: LANE_OP_W] =
                            ext_byte(a[BYTE_W*k +: BYTE_W], s1_op1_signed_i);
                        op2_d[LANE_OP_W*(l+k) +: LANE_OP_W] =
                            ext_byte(b[BYTE_W*k +: BYTE_W], s1_op2_signed_i);
                        acc_d[LANE_ACC_W*(l+k) +: LANE_ACC_W] =
                            {{(LANE_ACC_W-BYTE_W){1'b0}}, c[BYTE_W*k +: BYTE_W]};
                    end
                end
                VSEW_16: begin
                    // even lanes carry the halfword elements and odd lanes stay idle
                    for (int k = 0; k < 2; k++) begin
                        op1_d[LANE_OP_W*(l+2*k) +: LANE_OP_W] =
                            ext_half(a[HALF_W*k +: HALF_W], s1_op1_signed_i);
                        op2_d[LANE_OP_W*(l+2*k) +: LANE_OP_W] =
                            ext_half(b[HALF_W*k +: HALF_W], s1_op2_signed_i);
                        acc_d[LANE_ACC_W*(l+2*k) +: LANE_ACC_W] = c[HALF_W*k +: HALF_W];
                    end
                end
                VSEW_32: begin
                    // cross products lo*lo, lo*hi, hi*lo and hi*hi in lanes 0 to 3
                    for (int k = 0; k < 4; k++) begin
                        op1_d[LANE_OP_W*(l+k) +: LANE_OP_W] = (k < 2) ?
                            ext_half(a[0 +: HALF_W], 1'b0) :
                            ext_half(a[HALF_W +: HALF_W], s1_op1_signed_i);
                        op2_d[LANE_OP_W*(l+k) +: LANE_OP_W] = (k % 2 == 0) ?
                            ext_half(b[0 +: HALF_W], 1'b0) :
                            ext_half(b[HALF_W +: HALF_W], s1_op2_signed_i);
                    end
                    // upper accumulator half rides on the lane shifted by 16
                    acc_d[LANE_ACC_W*l +: LANE_ACC_W]     = c[0 +: HALF_W];
                    acc_d[LANE_ACC_W*(l+1) +: LANE_ACC_W] = c[HALF_W +: HALF_W];
                end
                default: ;
            endcase
        end
        if (s1_op_i != MUL_VMACC) begin
            acc_d = '0;
        end
    end

    always_ff @(posedge clk_i) begin : stage2_regs
        if (s2_en_i) begin
            op1_q <= op1_d;
            op2_q <= op2_d;
            acc_q <= acc_d;
        end
    end

    assign lane_op1_o = op1_q;
    assign lane_op2_o = op2_q;
    assign lane_acc_o = acc_q;

endmodule

`default_nettype wire

//--- design/vmul_pipe_ctrl.sv
//////////////////////////////
// valid/ready control of the four pipeline stages
// carries operation fields and the byte mask beside the data
//////////////////////////////

`default_nettype none

module vmul_pipe_ctrl import vmul_pkg::*; #(
    parameter int unsigned MUL_OP_W = 32
) (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         in_valid_i,
    input  logic                         in_masked_i,
    input  logic                         out_ready_i,
    input  vmul_op_e                     in_op_i,
    input  vmul_eew_e                    in_eew_i,
    input  logic                         in_op1_signed_i,
    input  logic                         in_op2_signed_i,
    input  logic [MUL_OP_W/BYTE_W-1:0]   in_mask_i,
    output logic                         in_ready_o,
    output logic                         out_valid_o,
    output logic                         s1_en_o,
    output logic                         s2_en_o,
    output logic                         s3_en_o,
    output logic                         s4_en_o,
    output vmul_op_e                     s1_op_o,
    output vmul_eew_e                    s1_eew_o,
    output logic                         s1_op1_signed_o,
    output logic                         s1_op2_signed_o,
    output vmul_op_e                     s3_op_o,
    output vmul_eew_e                    s3_eew_o,
    output logic [MUL_OP_W/BYTE_W-1:0]   out_mask_o
);

    localparam int unsigned LANES = MUL_OP_W / BYTE_W;

    logic             v1_q, v2_q, v3_q, v4_q;
    logic             rdy1, rdy2, rdy3, rdy4;
    vmul_op_e         op1_q, op2_q, op3_q;
    vmul_eew_e        eew1_q, eew2_q, eew3_q;
    logic             sgn1_q, sgn2_q;
    logic [LANES-1:0] mask1_q, mask2_q, mask3_q, mask4_q;

    // a stage accepts when it is empty or its content moves on
    assign rdy4 = ~v4_q | out_ready_i;
    assign rdy3 = ~v3_q | rdy4;
    assign rdy2 = ~v2_q | rdy3;
    assign rdy1 = ~v1_q | rdy2;

    assign s1_en_o = rdy1 & in_valid_i;
    assign s2_en_o = rdy2 & v1_q;
    assign s3_en_o = rdy3 & v2_q;
    assign s4_en_o = rdy4 & v3_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin : valid_regs
        if (!async_rst_ni) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
            v4_q <= 1'b0;
        end else begin
            if (rdy1) begin
                v1_q <= in_valid_i;
            end
            if (rdy2) begin
                v2_q <= v1_q;
            end
            if (rdy3) begin
                v3_q <= v2_q;
            end
            if (rdy4) begin
                v4_q <= v3_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin : field_regs
        if (s1_en_o) begin
            op1_q   <= in_op_i;
            eew1_q  <= in_eew_i;
            sgn1_q  <= in_op1_signed_i;
            sgn2_q  <= in_op2_signed_i;
            // unmasked items write every byte
            mask1_q <= in_masked_i ? in_mask_i : {LANES{1'b1}};
        end
        if (s2_en_o) begin
            op2_q   <= op1_q;
            eew2_q  <= eew1_q;
            mask2_q <= mask1_q;
        end
        if (s3_en_o) begin
            op3_q   <= op2_q;
            eew3_q  <= eew2_q;
            mask3_q <= mask2_q;
        end
        if (s4_en_o) begin
            mask4_q <= mask3_q;
        end
    end

    assign in_ready_o      = rdy1;
    assign out_valid_o     = v4_q;
    assign s1_op_o         = op1_q;
    assign s1_eew_o        = eew1_q;
    assign s1_op1_signed_o = sgn1_q;
    assign s1_op2_signed_o = sgn2_q;
    assign s3_op_o         = op3_q;
    assign s3_eew_o        = eew3_q;
    assign out_mask_o      = mask4_q;

endmodule

`default_nettype wire

//--- design/vmul_pkg.sv
//////////////////////////////
// shared widths and encodings for the SIMD multiplier
// imported by wildcard in each module header
//////////////////////////////

`default_nettype none

package vmul_pkg;

    //////////////////////////////
    // widths

    // element granule and mask bit granularity
    localparam int unsigned BYTE_W = 8;

    // signed operand width of one multiplier lane
    localparam int unsigned LANE_OP_W = 17;

    // accumulator slot added inside each lane
    localparam int unsigned LANE_ACC_W = 16;

    // lane product plus accumulator
    localparam int unsigned LANE_RES_W = 33;

    //////////////////////////////
    // encodings

    // element width of the vector operands
    typedef enum logic [1:0] {
        VSEW_8  = 2'd0,
        VSEW_16 = 2'd1,
        VSEW_32 = 2'd2
    } vmul_eew_e;

    // multiply operation
    typedef enum logic [1:0] {
        // low half of each element product
        MUL_VMUL  = 2'd0,
        // high half with per-operand signedness
        MUL_VMULH = 2'd1,
        // low half plus accumulator element
        MUL_VMACC = 2'd2
    } vmul_op_e;

endpackage

`default_nettype wire
